/* verilog/bus_pkg.sv */
package bus_pkg;

    // ==================================================
    // Widths
    // ==================================================

    // Payload word carried on the bus
    localparam int DATA_WIDTH = 32;

    // ==================================================
    // Pipeline and buffer defaults
    // ==================================================

    // Register stages between sender and receive buffer
    localparam int PIPE_STAGES = 4;

    // Receive buffer entries
    // Must cover 2*PIPE_STAGES + 2 so the skid still leaves room
    localparam int FIFO_DEPTH = 16;

    // Index and fill level widths follow the buffer depth
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_COUNT_WIDTH = FIFO_PTR_WIDTH + 1;

    // ==================================================
    // Types
    // ==================================================

    // One bus word
    typedef logic [DATA_WIDTH-1:0] bus_data_t;

    // Read or write slot in the buffer
    typedef logic [FIFO_PTR_WIDTH-1:0] fifo_ptr_t;

    // Fill level, one bit wider to hold a full buffer
    typedef logic [FIFO_COUNT_WIDTH-1:0] fifo_count_t;

endpackage

/* verilog/bus_intf.sv */
`timescale 1ns/1ps

interface bus_intf
    import bus_pkg::*;
();

    // ==================================================
    // Bus signals
    // ==================================================

    // Bus reset, issued by the sender and carried with the data
    logic srst;

    // Word qualifier, a word moves on every edge with valid high and srst low
    logic valid;

    // Payload
    bus_data_t data;

    // Room indication from the receiver
    // Advisory, and late by the number of stages it has crossed
    logic ready;

    // ==================================================
    // Modports
    // ==================================================

    // Sending end
    modport tx (
        output srst,
        output valid,
        output data,
        input  ready
    );

    // Receiving end
    modport rx (
        input  srst,
        input  valid,
        input  data,
        output ready
    );

endinterface

/* verilog/bus_pipe_stage.sv */
`timescale 1ns/1ps

module bus_pipe_stage (
    input logic clk,
    bus_intf.rx bus_if_from_tx,
    bus_intf.tx bus_if_to_rx
);

    // ==================================================
    // Forward path toward the receiver
    // ==================================================

    // Bus reset moves one stage per cycle, alongside the words
    always_ff @(posedge clk) begin
        bus_if_to_rx.srst <= bus_if_from_tx.srst;
    end

    // Valid is flushed while this stage sees the bus reset
    always_ff @(posedge clk) begin
        if (bus_if_from_tx.srst) begin
            bus_if_to_rx.valid <= 1'b0;
        end else begin
            bus_if_to_rx.valid <= bus_if_from_tx.valid;
        end
    end

    // Payload register
    // Only qualified by valid downstream
    always_ff @(posedge clk) begin
        bus_if_to_rx.data <= bus_if_from_tx.data;
    end

    // ==================================================
    // Backward path toward the sender
    // ==================================================

    // Ready is re-timed here too, one more cycle of lag per stage
    // The receive buffer's skid covers this delay
    // Held low during bus reset so the sender waits for the flush
    always_ff @(posedge clk) begin
        if (bus_if_from_tx.srst) begin
            bus_if_from_tx.ready <= 1'b0;
        end else begin
            bus_if_from_tx.ready <= bus_if_to_rx.ready;
        end
    end

    // Note the stage never looks at ready on the forward path,
    // a word in flight always moves on and the buffer takes it

endmodule

/* verilog/bus_pipe_fifo.sv */
`timescale 1ns/1ps

module bus_pipe_fifo
    import bus_pkg::*;
#(
    parameter int DEPTH = FIFO_DEPTH,
    parameter int SKID = 2 * PIPE_STAGES
) (
    input  logic      clk,
    bus_intf.rx       bus_if_from_tx,
    output logic      out_valid,
    output bus_data_t out_data,
    input  logic      out_ready
);

    // ==================================================
    // Room rule
    // ==================================================

    // Highest fill level that still grants ready upstream
    // Above it, the words already approved could overrun the buffer
    localparam fifo_count_t ROOM_LIMIT = fifo_count_t'(DEPTH - SKID - 1);

    // Last slot before the pointers wrap
    localparam fifo_ptr_t LAST_SLOT = fifo_ptr_t'(DEPTH - 1);

    // ==================================================
    // Storage and control state
    // ==================================================

    bus_data_t   mem [DEPTH];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;

    logic wr_en;
    logic rd_en;

    // Every word that shows up is taken, ready only limits the sender
    assign wr_en = bus_if_from_tx.valid && !bus_if_from_tx.srst;

    // Plain valid/ready transfer at the output
    assign rd_en = out_valid && out_ready;

    // ==================================================
    // Write side
    // ==================================================

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= bus_if_from_tx.data;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_if_from_tx.srst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            if (wr_ptr == LAST_SLOT) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // ==================================================
    // Read side
    // ==================================================

    always_ff @(posedge clk) begin
        if (bus_if_from_tx.srst) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            if (rd_ptr == LAST_SLOT) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Fill level
    // Simultaneous write and read leaves it unchanged
    always_ff @(posedge clk) begin
        if (bus_if_from_tx.srst) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ==================================================
    // Outputs
    // ==================================================

    // Head of the buffer, straight from storage
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    // Room decision, re-timed by each stage on its way to the sender
    assign bus_if_from_tx.ready = (count <= ROOM_LIMIT);

endmodule

/* verilog/bus_pipe.sv */
`timescale 1ns/1ps

module bus_pipe
    import bus_pkg::*;
#(
    parameter int STAGES = PIPE_STAGES
) (
    input  logic      clk,
    bus_intf.rx       bus_if_from_tx,
    output logic      out_valid,
    output bus_data_t out_data,
    input  logic      out_ready
);

    // ==================================================
    // Buffer sizing
    // ==================================================

    // Ready lags STAGES cycles back, words take STAGES cycles forward
    localparam int SKID_WORDS = 2 * STAGES;

    // At least the skid plus two entries, never below the default
    localparam int MIN_DEPTH = SKID_WORDS + 2;
    localparam int BUF_DEPTH = (MIN_DEPTH > FIFO_DEPTH) ? MIN_DEPTH : FIFO_DEPTH;

    // ==================================================
    // Stage chain
    // ==================================================

    generate
        if (STAGES == 0) begin : g_direct
            // No stages, buffer sits right at the sender
            bus_pipe_fifo #(
                .DEPTH (BUF_DEPTH),
                .SKID  (SKID_WORDS)
            ) u_fifo (
                .clk            (clk),
                .bus_if_from_tx (bus_if_from_tx),
                .out_valid      (out_valid),
                .out_data       (out_data),
                .out_ready      (out_ready)
            );
        end else begin : g_chain
            // Links between consecutive stages, last one feeds the buffer
            bus_intf bus_if_link [STAGES] ();

            bus_pipe_stage u_stage_first (
                .clk            (clk),
                .bus_if_from_tx (bus_if_from_tx),
                .bus_if_to_rx   (bus_if_link[0])
            );

            for (genvar i = 1; i < STAGES; i++) begin : g_stage
                bus_pipe_stage u_stage (
                    .clk            (clk),
                    .bus_if_from_tx (bus_if_link[i-1]),
                    .bus_if_to_rx   (bus_if_link[i])
                );
            end

            bus_pipe_fifo #(
                .DEPTH (BUF_DEPTH),
                .SKID  (SKID_WORDS)
            ) u_fifo (
                .clk            (clk),
                .bus_if_from_tx (bus_if_link[STAGES-1]),
                .out_valid      (out_valid),
                .out_data       (out_data),
                .out_ready      (out_ready)
            );
        end
    endgenerate

endmodule

/* verilog/bus_pipe_top.sv */
`timescale 1ns/1ps

module bus_pipe_top
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  bus_data_t in_data,
    output logic      in_ready,
    output logic      out_valid,
    output bus_data_t out_data,
    input  logic      out_ready
);

    // ==================================================
    // Sender side bus
    // ==================================================

    bus_intf bus_if ();

    // System reset enters the bus as its own srst
    assign bus_if.srst  = reset;
    assign bus_if.valid = in_valid;
    assign bus_if.data  = in_data;

    // Delayed room indication back to the sender
    assign in_ready = bus_if.ready;

    // ==================================================
    // Transport
    // ==================================================

    bus_pipe #(
        .STAGES (PIPE_STAGES)
    ) u_bus_pipe (
        .clk            (clk),
        .bus_if_from_tx (bus_if),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .out_ready      (out_ready)
    );

endmodule

/* dv/bus_pipe_properties.sv */
`timescale 1ns/1ps

module bus_pipe_properties
    import bus_pkg::*;
#(
    parameter int DEPTH = FIFO_DEPTH,
    parameter int SKID = 2 * PIPE_STAGES
) (
    input logic        clk,
    input logic        srst,
    input logic        ready,
    input logic        wr_en,
    input logic        rd_en,
    input fifo_ptr_t   wr_ptr,
    input fifo_ptr_t   rd_ptr,
    input fifo_count_t count
);

    // ==================================================
    // Buffer bounds
    // ==================================================

    // Every slot taken
    localparam fifo_count_t FULL = fifo_count_t'(DEPTH);

    // No write into a full buffer
    write_when_full: assert property (
        @(posedge clk) disable iff (srst) wr_en |-> count != FULL
    ) else $error("receive buffer written while full");

    // No read from an empty buffer
    // Equal pointers mean empty unless the count says full
    read_when_empty: assert property (
        @(posedge clk) disable iff (srst) rd_en |-> (rd_ptr != wr_ptr) || (count == FULL)
    ) else $error("receive buffer read while empty");

    // ==================================================
    // Room rule
    // ==================================================

    // A landing word had room granted SKID cycles before
    // Ready travels back and the word travels forward over the same stages
    arrival_without_room: assert property (
        @(posedge clk) disable iff (srst) wr_en |-> $past(ready, SKID)
    ) else $error("word arrived without room granted %0d cycles earlier", SKID);

endmodule

bind bus_pipe_fifo bus_pipe_properties #(
    .DEPTH (DEPTH),
    .SKID  (SKID)
) u_properties (
    .clk    (clk),
    .srst   (bus_if_from_tx.srst),
    .ready  (bus_if_from_tx.ready),
    .wr_en  (wr_en),
    .rd_en  (rd_en),
    .wr_ptr (wr_ptr),
    .rd_ptr (rd_ptr),
    .count  (count)
);

/* dv/bus_pipe_tb.sv */
`timescale 1ns/1ps

module bus_pipe_tb
    import bus_pkg::*;
();

    // ==================================================
    // Settings and signals
    // ==================================================

    localparam int CLK_HALF      = 10;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 5;
    localparam int READY_TIMEOUT = 4 * PIPE_STAGES + 16;
    localparam int DRAIN_TIMEOUT = FIFO_DEPTH + 4 * PIPE_STAGES + 16;
    localparam logic [31:0] LFSR_SEED = 32'd91179;

    logic      clk;
    logic      reset;
    logic      in_valid;
    bus_data_t in_data;
    logic      in_ready;
    logic      out_valid;
    bus_data_t out_data;
    logic      out_ready;

    // Expected words, oldest first
    bus_data_t model_q[$];

    logic [31:0] lfsr_state;
    int data_errors;
    int level_errors;
    int other_errors;
    int words_checked;

    // Steady stream tracking for the no-stall run
    bit steady_check;
    int stream_len;
    int stream_rx;

    bus_pipe_top DUT (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ==================================================
    // Random bits and compares
    // ==================================================

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic bus_data_t take_bits(input int n);
        bus_data_t bits;
        logic feedback;
        int i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            bits = {bits[DATA_WIDTH-2:0], lfsr_state[31]};
            lfsr_state = {lfsr_state[30:0], feedback};
        end
        return bits;
    endfunction

    task automatic check_word(input string name, input bus_data_t got, input bus_data_t exp);
        words_checked++;
        if (got !== exp) begin
            data_errors++;
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            level_errors++;
            $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // ==================================================
    // Monitor and model
    // ==================================================

    // Negedge sample, values here are what the next rising edge sees
    always @(negedge clk) begin
        if (reset) begin
            // Bus reset flushes everything in flight
            model_q.delete();
        end else begin
            if (steady_check && stream_rx > 0 && stream_rx < stream_len) begin
                check_level("out_valid", out_valid, 1'b1);
            end
            if (out_valid && out_ready) begin
                if (model_q.size() == 0) begin
                    other_errors++;
                    $display("Word %h left the pipe at %0t ns but none was expected",
                             out_data, $time);
                end else begin
                    check_word("out_data", out_data, model_q.pop_front());
                end
                stream_rx++;
            end
            // Sender only raises valid under ready, so this is the accept rule
            if (in_valid && in_ready) begin
                model_q.push_back(in_data);
            end
        end
    end

    // ==================================================
    // Stimulus tasks
    // ==================================================

    task automatic wait_in_ready();
        int waited;
        waited = 0;
        while (in_ready !== 1'b1 && waited < READY_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (in_ready !== 1'b1) begin
            other_errors++;
            $display("Timeout: in_ready still low %0d cycles after reset", waited);
        end
    endtask

    // Reset held for RESET_CYCLES edges, both ends quiet meanwhile
    task automatic apply_reset();
        @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b1;
        in_valid = 1'b0;
        out_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        out_ready = 1'b1;
        check_level("out_valid", out_valid, 1'b0);
        check_level("in_ready", in_ready, 1'b0);
        wait_in_ready();
    endtask

    task automatic drain_model();
        int waited;
        waited = 0;
        while (model_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (model_q.size() != 0) begin
            other_errors++;
            $display("Timeout: %0d words never left the pipe", model_q.size());
        end
    endtask

    // Accept at edge k, out_valid first seen at edge k+STAGES+1
    task automatic single_word_latency();
        bus_data_t word;
        int lat;
        word = take_bits(DATA_WIDTH);
        @(posedge clk);
        #DRIVE_DELAY;
        out_ready = 1'b1;
        in_valid = 1'b1;
        in_data = word;
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b0;
        for (lat = 1; lat <= PIPE_STAGES + 1; lat++) begin
            @(negedge clk);
            check_level("out_valid", out_valid, lat == PIPE_STAGES + 1);
        end
        check_word("out_data", out_data, word);
        drain_model();
    endtask

    // cut_cycle of zero runs until every word is out
    task automatic run_stream(input int n_words, input bit gaps, input bit stalls,
                              input int cut_cycle);
        int sent;
        int cycles;
        int limit;
        bit done;
        logic coin;
        sent = 0;
        cycles = 0;
        done = 1'b0;
        limit = 16 * n_words + 200;
        stream_len = n_words;
        stream_rx = 0;
        while (!done && cycles < limit) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
            if (cut_cycle != 0 && cycles > cut_cycle) begin
                break;
            end
            if (sent == n_words && model_q.size() == 0) begin
                done = 1'b1;
            end else begin
                coin = gaps ? (take_bits(2) != 0) : 1'b1;
                if (sent < n_words && in_ready === 1'b1 && coin) begin
                    in_valid = 1'b1;
                    in_data = take_bits(DATA_WIDTH);
                    sent++;
                end else begin
                    in_valid = 1'b0;
                end
                out_ready = stalls ? (take_bits(1) != 0) : 1'b1;
            end
        end
        in_valid = 1'b0;
        out_ready = 1'b1;
        if (cut_cycle == 0 && !done) begin
            other_errors++;
            $display("Timeout: stream of %0d words stuck, %0d sent, %0d left in the model",
                     n_words, sent, model_q.size());
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        out_ready = 1'b0;
        lfsr_state = LFSR_SEED;
        data_errors = 0;
        level_errors = 0;
        other_errors = 0;
        words_checked = 0;
        steady_check = 1'b0;
        stream_len = 0;
        stream_rx = 0;

        // Power-up reset and ready rise
        apply_reset();

        // Latency of one word
        single_word_latency();

        // Full rate, one word per cycle once filled
        steady_check = 1'b1;
        run_stream(1000, 1'b0, 1'b0, 0);
        steady_check = 1'b0;

        // Gaps, back-pressure, then both
        run_stream(300, 1'b1, 1'b0, 0);
        run_stream(300, 1'b0, 1'b1, 0);
        run_stream(400, 1'b1, 1'b1, 0);

        // Reset in mid-stream, then fresh traffic
        run_stream(400, 1'b1, 1'b1, 24 + int'(take_bits(5)));
        apply_reset();
        run_stream(300, 1'b1, 1'b1, 0);

        if (model_q.size() != 0) begin
            other_errors++;
            $display("Model queue still holds %0d words at the end", model_q.size());
        end

        $display("Checked %0d words: %0d data errors, %0d control errors, %0d other failures",
                 words_checked, data_errors, level_errors, other_errors);
        if (data_errors == 0 && level_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/bus_pkg.sv
verilog/bus_intf.sv
verilog/bus_pipe_stage.sv
verilog/bus_pipe_fifo.sv
verilog/bus_pipe.sv
verilog/bus_pipe_top.sv
dv/bus_pipe_properties.sv
dv/bus_pipe_tb.sv

/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -Wno-fatal
TOP       := bus_pipe_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

# Pass or fail comes from the log
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^Result: PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
